// ==== dv/wdemux_cases.txt ====
# name id(hex) addr(hex) port beats first_data(hex) expected_resp(hex)
# beat k carries first_data + k, B response equals the port
cap_0   3 00001000 1 2 10000000 1
cap_1   3 00001010 1 1 10000100 1
cap_2   3 00001020 1 3 10000200 1
cap_3   3 00001030 1 1 10000300 1
cap_4   3 00001040 1 2 10000400 1
cap_5   3 00001050 1 1 10000500 1
order_a 3 00002000 2 2 20000000 2
order_b 7 00002100 0 1 20000100 0
route_0 0 00003000 0 4 30000000 0
route_1 1 00003100 1 2 30000100 1
route_2 2 00003200 2 1 30000200 2
route_3 5 00003300 3 3 30000300 3
mix_0   0 00004000 0 2 40000000 0
mix_1   9 00004100 3 1 40000100 3
back_2  2 00004200 2 2 40000200 2
last_a  a 0000500c 1 1 5000000f 1

// ==== sources.f ====
rtl/wdemux_pkg.sv
rtl/id_track_if.sv
rtl/aw_dispatch_ctrl.sv
rtl/id_track_table.sv
rtl/w_route.sv
rtl/b_resp_arbiter.sv
rtl/axi_wdemux_top.sv
dv/clk_rst_gen.sv
dv/tb_axi_wdemux.sv

// ==== Makefile ====
# Verilator build and run of the write demux testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_wdemux
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_axi_wdemux.sv ====
// testbench for four ports; reads dv/wdemux_cases.txt from the project root, at most 64 cases
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wdemux;

  localparam int NUM_PORTS    = 4;
  localparam int MAX_TRANS    = 4;
  localparam int ID_LOOK_BITS = 2;
  localparam int MAX_CASES    = 64;
  // slave b_ready is held low this long after reset
  localparam int B_HOLD       = 80;

  logic clk;
  logic reset;

  // slave side driven by the stimulus processes
  logic                  s_aw_valid = 1'b0;
  wdemux_pkg::axi_id_t   s_aw_id    = '0;
  wdemux_pkg::axi_addr_t s_aw_addr  = '0;
  wdemux_pkg::port_sel_t s_aw_sel   = '0;
  logic                  s_w_valid  = 1'b0;
  wdemux_pkg::axi_data_t s_w_data   = '0;
  logic                  s_w_last   = 1'b0;
  logic                  s_b_ready  = 1'b0;
  logic                  s_aw_ready_o;
  logic                  s_w_ready_o;
  logic                  s_b_valid_o;
  wdemux_pkg::axi_id_t   s_b_id_o;
  wdemux_pkg::axi_resp_t s_b_resp_o;

  // master side driven by the port models
  logic [NUM_PORTS-1:0]                  m_aw_ready = '0;
  logic [NUM_PORTS-1:0]                  m_w_ready  = '0;
  logic [NUM_PORTS-1:0]                  m_b_valid  = '0;
  wdemux_pkg::axi_id_t [NUM_PORTS-1:0]   m_b_id     = '0;
  wdemux_pkg::axi_resp_t [NUM_PORTS-1:0] m_b_resp   = '0;
  logic [NUM_PORTS-1:0]                  m_aw_valid_o;
  wdemux_pkg::axi_id_t [NUM_PORTS-1:0]   m_aw_id_o;
  wdemux_pkg::axi_addr_t [NUM_PORTS-1:0] m_aw_addr_o;
  logic [NUM_PORTS-1:0]                  m_w_valid_o;
  wdemux_pkg::axi_data_t [NUM_PORTS-1:0] m_w_data_o;
  logic [NUM_PORTS-1:0]                  m_w_last_o;
  logic [NUM_PORTS-1:0]                  m_b_ready_o;

  // case table loaded from the data file
  string                 c_name  [MAX_CASES];
  wdemux_pkg::axi_id_t   c_id    [MAX_CASES];
  wdemux_pkg::axi_addr_t c_addr  [MAX_CASES];
  wdemux_pkg::port_sel_t c_port  [MAX_CASES];
  int                    c_beats [MAX_CASES];
  wdemux_pkg::axi_data_t c_data  [MAX_CASES];
  wdemux_pkg::axi_resp_t c_resp  [MAX_CASES];
  logic                  aw_done [MAX_CASES];
  int                    n_cases     = 0;
  int                    total_beats = 0;

  // scoreboard state owned by the bus model block
  int          aw_seen    = 0;
  int          w_seen     = 0;
  int          w_beat     = 0;
  int          b_seen     = 0;
  int          cycle      = 0;
  int          val_errs   = 0;
  int          proto_errs = 0;
  int          out_cnt  [16];
  int          out_port [16];
  int          exp_b    [16][$];
  int          b_pend   [NUM_PORTS][$];
  logic [31:0] lfsr     = 32'hb24fc46b;

  clk_rst_gen clk_rst_gen_inst (
    .clk_o   (clk),
    .reset_o (reset)
  );

  axi_wdemux_top #(
    .NUM_PORTS    (NUM_PORTS),
    .MAX_TRANS    (MAX_TRANS),
    .ID_LOOK_BITS (ID_LOOK_BITS)
  ) axi_wdemux_top_inst (
    .clk_i        (clk),
    .reset_i      (reset),
    .s_aw_valid_i (s_aw_valid),
    .s_aw_ready_o (s_aw_ready_o),
    .s_aw_id_i    (s_aw_id),
    .s_aw_addr_i  (s_aw_addr),
    .s_aw_sel_i   (s_aw_sel),
    .s_w_valid_i  (s_w_valid),
    .s_w_ready_o  (s_w_ready_o),
    .s_w_data_i   (s_w_data),
    .s_w_last_i   (s_w_last),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready),
    .s_b_id_o     (s_b_id_o),
    .s_b_resp_o   (s_b_resp_o),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready),
    .m_aw_id_o    (m_aw_id_o),
    .m_aw_addr_o  (m_aw_addr_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_w_ready_i  (m_w_ready),
    .m_w_data_o   (m_w_data_o),
    .m_w_last_o   (m_w_last_o),
    .m_b_valid_i  (m_b_valid),
    .m_b_ready_o  (m_b_ready_o),
    .m_b_id_i     (m_b_id),
    .m_b_resp_i   (m_b_resp)
  );

  // --------------------------------------------------------------------------
  // random bits and compare tasks
  // --------------------------------------------------------------------------
  // galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  task automatic compare_addr(input string name, input wdemux_pkg::axi_addr_t exp_v,
                              input wdemux_pkg::axi_addr_t act_v);
    if (exp_v !== act_v) begin
      val_errs++;
      $display("Fail %s addr expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic compare_data(input string name, input wdemux_pkg::axi_data_t exp_v,
                              input wdemux_pkg::axi_data_t act_v);
    if (exp_v !== act_v) begin
      val_errs++;
      $display("Fail %s data expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic compare_id(input string name, input wdemux_pkg::axi_id_t exp_v,
                            input wdemux_pkg::axi_id_t act_v);
    if (exp_v !== act_v) begin
      val_errs++;
      $display("Fail %s id expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic compare_resp(input string name, input wdemux_pkg::axi_resp_t exp_v,
                              input wdemux_pkg::axi_resp_t act_v);
    if (exp_v !== act_v) begin
      val_errs++;
      $display("Fail %s resp expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic compare_last(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      val_errs++;
      $display("Fail %s last expected %b actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic protocol_error(input string what);
    proto_errs++;
    $display("error at cycle %0d: %s", cycle, what);
  endtask

  // --------------------------------------------------------------------------
  // master port models and scoreboard sampled on the rising edge
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    int c;
    int id;
    if (reset) begin
      m_aw_ready <= '0;
      m_w_ready  <= '0;
      m_b_valid  <= '0;
      s_b_ready  <= 1'b0;
    end else begin
      cycle++;
      for (int p = 0; p < NUM_PORTS; p++) begin
        // AW goes only to the port of the presented case
        if (m_aw_valid_o[p]) begin
          if (aw_seen >= n_cases || p != int'(c_port[aw_seen])) begin
            protocol_error($sformatf("AW valid on port %0d which was not selected", p));
          end else if (m_aw_ready[p]) begin
            c  = aw_seen;
            id = int'(c_id[c]);
            compare_id(c_name[c], c_id[c], m_aw_id_o[p]);
            compare_addr(c_name[c], c_addr[c], m_aw_addr_o[p]);
            if (out_cnt[id] != 0 && out_port[id] != p) begin
              protocol_error($sformatf("%s issued to port %0d while its ID is busy on %0d",
                                       c_name[c], p, out_port[id]));
            end
            out_cnt[id]++;
            out_port[id] = p;
            if (out_cnt[id] > MAX_TRANS) begin
              protocol_error($sformatf("more than %0d writes in flight for ID %0d",
                                       MAX_TRANS, id));
            end
            exp_b[id].push_back(c);
            aw_done[c] = 1'b1;
            aw_seen++;
          end
        end
        // W beats arrive in case order
        if (m_w_valid_o[p] && m_w_ready[p]) begin
          if (w_seen >= n_cases || p != int'(c_port[w_seen])) begin
            protocol_error($sformatf("W beat on port %0d out of AW order", p));
          end else begin
            c = w_seen;
            compare_data(c_name[c], c_data[c] + wdemux_pkg::axi_data_t'(w_beat),
                         m_w_data_o[p]);
            compare_last(c_name[c], w_beat == c_beats[c] - 1, m_w_last_o[p]);
            if (m_w_last_o[p]) begin
              b_pend[p].push_back(c);
              w_seen++;
              w_beat = 0;
            end else begin
              w_beat++;
            end
          end
        end
        // B once both AW and the last beat have been taken
        if (m_b_valid[p] && m_b_ready_o[p]) begin
          m_b_valid[p] <= 1'b0;
        end else if (!m_b_valid[p] && b_pend[p].size() > 0) begin
          if (aw_done[b_pend[p][0]]) begin
            c = b_pend[p].pop_front();
            m_b_valid[p] <= 1'b1;
            m_b_id[p]    <= c_id[c];
            m_b_resp[p]  <= wdemux_pkg::axi_resp_t'(p);
          end
        end
        m_aw_ready[p] <= rand_bit();
        m_w_ready[p]  <= rand_bit();
      end
      // merged B where the same ID keeps issue order
      if (s_b_valid_o && s_b_ready) begin
        id = int'(s_b_id_o);
        if (exp_b[id].size() == 0) begin
          protocol_error($sformatf("B for ID %0d with no write in flight", id));
        end else begin
          c = exp_b[id].pop_front();
          compare_resp(c_name[c], c_resp[c], s_b_resp_o);
          out_cnt[id]--;
          b_seen++;
        end
      end
      s_b_ready <= (cycle < B_HOLD) ? 1'b0 : rand_bit();
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic load_cases(output bit ok);
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] id;
    logic [31:0] addr;
    logic [31:0] port;
    int          beats;
    logic [31:0] data;
    logic [31:0] resp;
    ok = 1'b0;
    fd = $fopen("dv/wdemux_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        n = $fgets(line, fd);
        if (n > 2 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%s %h %h %h %d %h %h", name, id, addr, port, beats, data, resp);
          if (n == 7) begin
            c_name[n_cases]  = name;
            c_id[n_cases]    = wdemux_pkg::axi_id_t'(id);
            c_addr[n_cases]  = addr;
            c_port[n_cases]  = wdemux_pkg::port_sel_t'(port);
            c_beats[n_cases] = beats;
            c_data[n_cases]  = data;
            c_resp[n_cases]  = wdemux_pkg::axi_resp_t'(resp);
            aw_done[n_cases] = 1'b0;
            total_beats += beats;
            n_cases++;
          end
        end
      end
      $fclose(fd);
      ok = (n_cases > 0);
    end
  endtask

  task automatic drive_aw();
    for (int i = 0; i < n_cases; i++) begin
      s_aw_valid <= 1'b1;
      s_aw_id    <= c_id[i];
      s_aw_addr  <= c_addr[i];
      s_aw_sel   <= c_port[i];
      do @(posedge clk); while (!s_aw_ready_o);
    end
    s_aw_valid <= 1'b0;
  endtask

  task automatic drive_w();
    for (int i = 0; i < n_cases; i++) begin
      for (int k = 0; k < c_beats[i]; k++) begin
        s_w_valid <= 1'b1;
        s_w_data  <= c_data[i] + wdemux_pkg::axi_data_t'(k);
        s_w_last  <= (k == c_beats[i] - 1);
        do @(posedge clk); while (!s_w_ready_o);
      end
    end
    s_w_valid <= 1'b0;
    s_w_last  <= 1'b0;
  endtask

  initial begin
    bit loaded;
    for (int i = 0; i < 16; i++) begin
      out_cnt[i]  = 0;
      out_port[i] = 0;
    end
    load_cases(loaded);
    if (!loaded) begin
      $display("no case could be read from dv/wdemux_cases.txt");
      $display("Result: FAILED");
    end else begin
      wait (!reset);
      @(posedge clk);
      fork
        drive_aw();
        drive_w();
      join
      wait (b_seen == n_cases);
      repeat (4) @(posedge clk);
      $display("errors: %0d value, %0d protocol, %0d of %0d cases done",
               val_errs, proto_errs, b_seen, n_cases);
      if (val_errs == 0 && proto_errs == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
    end
    $finish;
  end

  // watchdog scaled by the case count and the beat count
  initial begin
    int limit;
    wait (n_cases > 0);
    limit = n_cases * total_beats * 200;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, %0d value and %0d protocol errors, %0d of %0d seen",
             limit, val_errs, proto_errs, b_seen, n_cases);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/clk_rst_gen.sv ====
// testbench clock and reset; reset is released on a rising edge after RESET_CYCLES cycles
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== rtl/axi_wdemux_top.sv ====
// write-only AXI demux for 2 to 4 ports; s_aw_sel_i must name an existing port while valid
`timescale 1ns/1ps
`default_nettype none

module axi_wdemux_top #(
  parameter int NUM_PORTS    = 4,
  parameter int MAX_TRANS    = 4,
  parameter int ID_LOOK_BITS = 2
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   reset_i,
  // slave AW
  input  wire logic                                   s_aw_valid_i,
  output logic                                        s_aw_ready_o,
  input  wire wdemux_pkg::axi_id_t                    s_aw_id_i,
  input  wire wdemux_pkg::axi_addr_t                  s_aw_addr_i,
  input  wire wdemux_pkg::port_sel_t                  s_aw_sel_i,
  // slave W
  input  wire logic                                   s_w_valid_i,
  output logic                                        s_w_ready_o,
  input  wire wdemux_pkg::axi_data_t                  s_w_data_i,
  input  wire logic                                   s_w_last_i,
  // slave B
  output logic                                        s_b_valid_o,
  input  wire logic                                   s_b_ready_i,
  output wdemux_pkg::axi_id_t                         s_b_id_o,
  output wdemux_pkg::axi_resp_t                       s_b_resp_o,
  // master AW
  output logic [NUM_PORTS-1:0]                        m_aw_valid_o,
  input  wire logic [NUM_PORTS-1:0]                   m_aw_ready_i,
  output wdemux_pkg::axi_id_t [NUM_PORTS-1:0]         m_aw_id_o,
  output wdemux_pkg::axi_addr_t [NUM_PORTS-1:0]       m_aw_addr_o,
  // master W
  output logic [NUM_PORTS-1:0]                        m_w_valid_o,
  input  wire logic [NUM_PORTS-1:0]                   m_w_ready_i,
  output wdemux_pkg::axi_data_t [NUM_PORTS-1:0]       m_w_data_o,
  output logic [NUM_PORTS-1:0]                        m_w_last_o,
  // master B
  input  wire logic [NUM_PORTS-1:0]                   m_b_valid_i,
  output logic [NUM_PORTS-1:0]                        m_b_ready_o,
  input  wire wdemux_pkg::axi_id_t [NUM_PORTS-1:0]    m_b_id_i,
  input  wire wdemux_pkg::axi_resp_t [NUM_PORTS-1:0]  m_b_resp_i
);

  logic                    fifo_push;
  logic                    fifo_full;
  logic                    b_pop;
  logic [ID_LOOK_BITS-1:0] b_pop_id;

  id_track_if #(.ID_LOOK_BITS(ID_LOOK_BITS)) trk ();

  // B completion releases the ID table entry
  assign trk.pop    = b_pop;
  assign trk.pop_id = b_pop_id;

  // AW payload goes to every port, valid picks one
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_aw_payload
    assign m_aw_id_o[i]   = s_aw_id_i;
    assign m_aw_addr_o[i] = s_aw_addr_i;
  end

  aw_dispatch_ctrl #(
    .NUM_PORTS    (NUM_PORTS),
    .ID_LOOK_BITS (ID_LOOK_BITS)
  ) aw_dispatch_ctrl_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .aw_valid_i   (s_aw_valid_i),
    .aw_ready_o   (s_aw_ready_o),
    .aw_id_i      (s_aw_id_i),
    .aw_sel_i     (s_aw_sel_i),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .fifo_push_o  (fifo_push),
    .fifo_full_i  (fifo_full),
    .trk_o        (trk.ctrl)
  );

  id_track_table #(
    .MAX_TRANS    (MAX_TRANS),
    .ID_LOOK_BITS (ID_LOOK_BITS)
  ) id_track_table_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .trk_i   (trk.tbl)
  );

  w_route #(
    .NUM_PORTS (NUM_PORTS),
    .MAX_TRANS (MAX_TRANS)
  ) w_route_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (fifo_push),
    .sel_i       (s_aw_sel_i),
    .full_o      (fifo_full),
    .w_valid_i   (s_w_valid_i),
    .w_ready_o   (s_w_ready_o),
    .w_data_i    (s_w_data_i),
    .w_last_i    (s_w_last_i),
    .m_w_valid_o (m_w_valid_o),
    .m_w_ready_i (m_w_ready_i),
    .m_w_data_o  (m_w_data_o),
    .m_w_last_o  (m_w_last_o)
  );

  b_resp_arbiter #(
    .NUM_PORTS    (NUM_PORTS),
    .ID_LOOK_BITS (ID_LOOK_BITS)
  ) b_resp_arbiter_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .m_b_valid_i (m_b_valid_i),
    .m_b_ready_o (m_b_ready_o),
    .m_b_id_i    (m_b_id_i),
    .m_b_resp_i  (m_b_resp_i),
    .b_valid_o   (s_b_valid_o),
    .b_ready_i   (s_b_ready_i),
    .b_id_o      (s_b_id_o),
    .b_resp_o    (s_b_resp_o),
    .pop_o       (b_pop),
    .pop_id_o    (b_pop_id)
  );

endmodule

`default_nettype wire

// ==== rtl/b_resp_arbiter.sv ====
// B merge; masters must hold b_valid and payload until b_ready, or the locked grant stalls
`timescale 1ns/1ps
`default_nettype none

module b_resp_arbiter #(
  parameter int NUM_PORTS    = 4,
  parameter int ID_LOOK_BITS = 2
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   reset_i,
  // master B
  input  wire logic [NUM_PORTS-1:0]                   m_b_valid_i,
  output logic [NUM_PORTS-1:0]                        m_b_ready_o,
  input  wire wdemux_pkg::axi_id_t [NUM_PORTS-1:0]    m_b_id_i,
  input  wire wdemux_pkg::axi_resp_t [NUM_PORTS-1:0]  m_b_resp_i,
  // slave B
  output logic                                        b_valid_o,
  input  wire logic                                   b_ready_i,
  output wdemux_pkg::axi_id_t                         b_id_o,
  output wdemux_pkg::axi_resp_t                       b_resp_o,
  // ID table release
  output logic                                        pop_o,
  output logic [ID_LOOK_BITS-1:0]                     pop_id_o
);

  // last served port, search starts just above it
  wdemux_pkg::port_sel_t rr_q;
  wdemux_pkg::port_sel_t lock_idx_q;
  logic                  lock_q;
  wdemux_pkg::port_sel_t pick;
  wdemux_pkg::port_sel_t gnt;

  // --------------------------------------------------------------------------
  // round-robin search
  // --------------------------------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    pick  = rr_q;
    found = 1'b0;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(rr_q) + k) % NUM_PORTS;
      if (!found && m_b_valid_i[idx]) begin
        found = 1'b1;
        pick  = wdemux_pkg::port_sel_t'(idx);
      end
    end
  end

  // a stalled response keeps its grant
  assign gnt = lock_q ? lock_idx_q : pick;

  always_comb begin
    b_valid_o   = 1'b0;
    b_id_o      = '0;
    b_resp_o    = '0;
    m_b_ready_o = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (gnt == wdemux_pkg::port_sel_t'(i)) begin
        b_valid_o      = m_b_valid_i[i];
        b_id_o         = m_b_id_i[i];
        b_resp_o       = m_b_resp_i[i];
        m_b_ready_o[i] = b_ready_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= wdemux_pkg::port_sel_t'(NUM_PORTS - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (b_valid_o && b_ready_i) begin
      lock_q <= 1'b0;
      rr_q   <= gnt;
    end else if (b_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt;
    end
  end

  // completed response frees one entry of its ID
  assign pop_o    = b_valid_o && b_ready_i;
  assign pop_id_o = b_id_o[ID_LOOK_BITS-1:0];

endmodule

`default_nettype wire

// ==== rtl/w_route.sv ====
// W steering in AW order; no fall-through, so W waits one cycle after its AW is pushed
`timescale 1ns/1ps
`default_nettype none

module w_route #(
  parameter int NUM_PORTS = 4,
  parameter int MAX_TRANS = 4
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   reset_i,
  // selection FIFO
  input  wire logic                                   push_i,
  input  wire wdemux_pkg::port_sel_t                  sel_i,
  output logic                                        full_o,
  // slave W
  input  wire logic                                   w_valid_i,
  output logic                                        w_ready_o,
  input  wire wdemux_pkg::axi_data_t                  w_data_i,
  input  wire logic                                   w_last_i,
  // master W
  output logic [NUM_PORTS-1:0]                        m_w_valid_o,
  input  wire logic [NUM_PORTS-1:0]                   m_w_ready_i,
  output wdemux_pkg::axi_data_t [NUM_PORTS-1:0]       m_w_data_o,
  output logic [NUM_PORTS-1:0]                        m_w_last_o
);

  localparam int PTR_W = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;
  localparam int CNT_W = $clog2(MAX_TRANS + 1);

  wdemux_pkg::port_sel_t mem_q [MAX_TRANS];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  empty;
  logic                  pop;
  wdemux_pkg::port_sel_t head;

  assign empty  = (count_q == '0);
  assign full_o = (count_q == CNT_W'(MAX_TRANS));
  assign head   = mem_q[rd_ptr_q];
  // head retires with the last beat of its burst
  assign pop    = !empty && w_valid_i && w_ready_o && w_last_i;

  // --------------------------------------------------------------------------
  // selection FIFO
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= sel_i;
    end
  end

  // --------------------------------------------------------------------------
  // beat steering
  // --------------------------------------------------------------------------
  always_comb begin
    m_w_valid_o = '0;
    w_ready_o   = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (!empty && (head == wdemux_pkg::port_sel_t'(i))) begin
        m_w_valid_o[i] = w_valid_i;
        w_ready_o      = m_w_ready_i[i];
      end
    end
  end

  // payload fans out, only valid is steered
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_w_payload
    assign m_w_data_o[i] = w_data_i;
    assign m_w_last_o[i] = w_last_i;
  end

endmodule

`default_nettype wire

// ==== rtl/id_track_table.sv ====
// in-flight writes per low ID; a pop for an ID with no writes in flight is not guarded
`timescale 1ns/1ps
`default_nettype none

module id_track_table #(
  parameter int MAX_TRANS    = 4,
  parameter int ID_LOOK_BITS = 2
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  id_track_if.tbl   trk_i
);

  localparam int NUM_IDS = 2 ** ID_LOOK_BITS;
  // counter must reach MAX_TRANS itself
  localparam int CNT_W   = $clog2(MAX_TRANS + 1);

  wdemux_pkg::port_sel_t port_v     [NUM_IDS];
  logic [NUM_IDS-1:0]    occupied_v;
  logic [NUM_IDS-1:0]    full_v;

  // --------------------------------------------------------------------------
  // one counter and port register per tracked ID
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_IDS; i++) begin : gen_id
    logic [CNT_W-1:0]      cnt_q;
    wdemux_pkg::port_sel_t port_q;
    logic                  inc;
    logic                  dec;

    assign inc = trk_i.push && (trk_i.push_id == ID_LOOK_BITS'(i));
    assign dec = trk_i.pop && (trk_i.pop_id == ID_LOOK_BITS'(i));

    // push and pop together cancel out
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        cnt_q <= '0;
      end else if (inc && !dec) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (dec && !inc) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // port of the latest push, same for all in-flight writes of this ID
    always_ff @(posedge clk_i) begin
      if (inc) begin
        port_q <= trk_i.push_port;
      end
    end

    assign port_v[i]     = port_q;
    assign occupied_v[i] = (cnt_q != '0);
    assign full_v[i]     = (cnt_q == CNT_W'(MAX_TRANS));
  end

  // lookup of the presented AW
  assign trk_i.lookup_port = port_v[trk_i.lookup_id];
  assign trk_i.occupied    = occupied_v[trk_i.lookup_id];
  // any saturated ID stalls all admissions
  assign trk_i.full        = |full_v;

endmodule

`default_nettype wire

// ==== rtl/aw_dispatch_ctrl.sv ====
// AW admission; the slave AW payload and select must stay stable while aw_valid_i is high
`timescale 1ns/1ps
`default_nettype none

module aw_dispatch_ctrl #(
  parameter int NUM_PORTS    = 4,
  parameter int ID_LOOK_BITS = 2
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  // slave AW
  input  wire logic                  aw_valid_i,
  output logic                       aw_ready_o,
  input  wire wdemux_pkg::axi_id_t   aw_id_i,
  input  wire wdemux_pkg::port_sel_t aw_sel_i,
  // master AW handshake
  output logic [NUM_PORTS-1:0]       m_aw_valid_o,
  input  wire logic [NUM_PORTS-1:0]  m_aw_ready_i,
  // select FIFO in w_route
  output logic                       fifo_push_o,
  input  wire logic                  fifo_full_i,
  // ID table
  id_track_if.ctrl                   trk_o
);

  wdemux_pkg::aw_state_e state_q, state_d;
  logic                  sel_ready;
  logic                  aw_go;
  logic                  push;

  // ready of the selected master port
  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (aw_sel_i == wdemux_pkg::port_sel_t'(i)) begin
        sel_ready = m_aw_ready_i[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // admission and valid lock
  // --------------------------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    aw_go      = 1'b0;
    push       = 1'b0;
    aw_ready_o = 1'b0;
    case (state_q)
      wdemux_pkg::AW_IDLE: begin
        // capacity in table and FIFO, and no in-flight writes of this ID elsewhere
        if (aw_valid_i && !trk_o.full && !fifo_full_i &&
            (!trk_o.occupied || (trk_o.lookup_port == aw_sel_i))) begin
          aw_go = 1'b1;
          // table and FIFO take the AW now, the master may accept later
          push  = 1'b1;
          if (sel_ready) begin
            aw_ready_o = 1'b1;
          end else begin
            state_d = wdemux_pkg::AW_LOCKED;
          end
        end
      end
      wdemux_pkg::AW_LOCKED: begin
        // already pushed, only wait for the master
        aw_go = 1'b1;
        if (sel_ready) begin
          aw_ready_o = 1'b1;
          state_d    = wdemux_pkg::AW_IDLE;
        end
      end
      default: state_d = wdemux_pkg::AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= wdemux_pkg::AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // valid only toward the selected port
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      m_aw_valid_o[i] = aw_go && (aw_sel_i == wdemux_pkg::port_sel_t'(i));
    end
  end

  assign trk_o.lookup_id = aw_id_i[ID_LOOK_BITS-1:0];
  assign trk_o.push_id   = aw_id_i[ID_LOOK_BITS-1:0];
  assign trk_o.push_port = aw_sel_i;
  assign trk_o.push      = push;
  assign fifo_push_o     = push;

endmodule

`default_nettype wire

// ==== rtl/id_track_if.sv ====
// ID table handshake; ID_LOOK_BITS must match the AW control, the table and the top level
`timescale 1ns/1ps
`default_nettype none

interface id_track_if #(
  parameter int ID_LOOK_BITS = 2
);

  // lookup of the AW currently presented
  logic [ID_LOOK_BITS-1:0] lookup_id;
  wdemux_pkg::port_sel_t   lookup_port;
  logic                    occupied;
  // set when any tracked ID is at its in-flight limit
  logic                    full;

  // one push per admitted AW
  logic                    push;
  logic [ID_LOOK_BITS-1:0] push_id;
  wdemux_pkg::port_sel_t   push_port;

  // pop on every slave-side B handshake
  logic                    pop;
  logic [ID_LOOK_BITS-1:0] pop_id;

  modport ctrl (
    output lookup_id, push, push_id, push_port,
    input  lookup_port, occupied, full
  );

  // table side, pop arrives from the B arbiter through the top level
  modport tbl (
    input  lookup_id, push, push_id, push_port, pop, pop_id,
    output lookup_port, occupied, full
  );

endinterface

`default_nettype wire

// ==== rtl/wdemux_pkg.sv ====
// shared AXI widths and types; PORT_SEL_W of 2 limits the design to at most four master ports
`default_nettype none

package wdemux_pkg;

  // --------------------------------------------------------------------------
  // channel widths
  // --------------------------------------------------------------------------
  localparam int ID_W       = 4;
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  // port number, enough for four master ports
  localparam int PORT_SEL_W = 2;
  localparam int RESP_W     = 2;

  // --------------------------------------------------------------------------
  // payload types
  // --------------------------------------------------------------------------
  typedef logic [ID_W-1:0]       axi_id_t;
  typedef logic [ADDR_W-1:0]     axi_addr_t;
  typedef logic [DATA_W-1:0]     axi_data_t;
  typedef logic [PORT_SEL_W-1:0] port_sel_t;
  typedef logic [RESP_W-1:0]     axi_resp_t;

  // AW control: idle, or valid held toward a master that has not accepted yet
  typedef enum logic {
    AW_IDLE,
    AW_LOCKED
  } aw_state_e;

endpackage

`default_nettype wire
